//--- flist.f
wb_pkg.sv
i2c_pkg.sv
i2c_reg_decode.sv
i2c_byte_engine.sv
i2c_read_result.sv
i2c_read_master.sv
tb_clock_gen.sv
tb_i2c_target.sv
tb_i2c_read_master.sv

//--- run.sh
#!/bin/bash
# build and run the I2C register master testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --top-module tb_i2c_read_master \
   -f flist.f \
   -o sim_tb || exit 1

out="$(./obj_dir/sim_tb 2>&1)"
echo "$out"
echo "$out" | grep -qF '*** TEST PASSED ***' && exit 0 || exit 1

//--- tb_i2c_read_master.sv
module tb_i2c_read_master;
   timeunit 1ns;
   timeprecision 100ps;
   import wb_pkg::*;
   import i2c_pkg::*;

   typedef struct packed {
      cmd_op_e    op;
      logic [7:0] ptr;
      logic [7:0] wdata;
      logic       mute;
      logic       expect_nack;
      logic [7:0] expect_rdata;
   } test_vec_t;

   localparam int NUM_VEC = 8;

   logic       clk_4x;
   logic       reset;
   wb_req_t    wb_req;
   wb_rsp_t    wb_rsp;
   logic       scl_low;
   logic       sda_low;
   logic       sda_line;
   logic       mute;
   int         stop_count;
   test_vec_t  vec_table [NUM_VEC];
   logic [7:0] ref_mem [256];  // expected target contents
   logic [7:0] last_good;
   int         seed;
   int         errors;
   int         passes;
   int         fails;
   logic       timed_out;

   tb_clock_gen i_clk (.clk_4x(clk_4x), .reset(reset));

   i2c_read_master #(.TARGET_ADDR(7'h68)) i_dut (
      .clk_4x   (clk_4x),
      .reset    (reset),
      .wb_req   (wb_req),
      .wb_rsp   (wb_rsp),
      .scl_low  (scl_low),
      .sda_low  (sda_low),
      .sda_line (sda_line)
   );

   tb_i2c_target #(.ADDR(7'h68)) i_target (
      .clk        (clk_4x),
      .scl_low    (scl_low),
      .sda_low    (sda_low),
      .mute       (mute),
      .sda_line   (sda_line),
      .stop_count (stop_count)
   );

   task automatic check(input string name, input logic [15:0] expected,
                        input logic [15:0] actual);
      if (expected !== actual) begin
         $display("Mismatch %s expected %h got %h", name, expected, actual);
         errors++;
      end
   endtask

   // stb stays high into the cycle after ack where ack must be low again
   task automatic wb_access(input logic we, input logic [1:0] adr,
                            input logic [15:0] wdat, output logic [15:0] rdat);
      logic seen;
      seen = 1'b0;
      rdat = '0;
      if (timed_out) return;
      @(posedge clk_4x);
      #1;
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we  = we;
      wb_req.adr = adr;
      wb_req.dat = wdat;
      for (int n = 0; n < 16 && !seen; n++) begin
         @(posedge clk_4x);
         #1;
         if (wb_rsp.ack) begin
            seen = 1'b1;
            rdat = wb_rsp.dat;
         end
      end
      if (seen) begin
         @(posedge clk_4x);
         #1;
         check("wb_rsp.ack", 16'd0, {15'd0, wb_rsp.ack});
      end
      wb_req.cyc = 1'b0;
      wb_req.stb = 1'b0;
      wb_req.we  = 1'b0;
      if (!seen) begin
         $display("no ack for register %0d within 16 cycles", adr);
         timed_out = 1'b1;
      end
   endtask

   task automatic wb_write(input logic [1:0] adr, input logic [15:0] wdat);
      logic [15:0] unused_dat;
      wb_access(1'b1, adr, wdat, unused_dat);
   endtask

   task automatic wb_read(input logic [1:0] adr, output logic [15:0] rdat);
      wb_access(1'b0, adr, 16'd0, rdat);
   endtask

   task automatic poll_done(output logic [15:0] st);
      logic got;
      got = 1'b0;
      st  = '0;
      for (int n = 0; n < 300 && !got && !timed_out; n++) begin
         wb_read(REG_STATUS, st);
         got = st[STAT_DONE];
      end
      if (!got && !timed_out) begin
         $display("status never showed done within 300 polls");
         timed_out = 1'b1;
      end
   endtask

   task automatic report_test(input string name, input int err_before);
      if (errors == err_before && !timed_out) begin
         passes++;
         $display("test %s ok", name);
      end else begin
         fails++;
         $display("test %s failed", name);
      end
   endtask

   // register i holds i ^ a5 until written
   task automatic set_entry(input int idx, input cmd_op_e op, input logic [7:0] ptr,
                            input logic [7:0] wdata, input logic mute_on);
      test_vec_t v;
      v.op          = op;
      v.ptr         = ptr;
      v.wdata       = wdata;
      v.mute        = mute_on;
      v.expect_nack = mute_on;
      if (!mute_on && op == OP_WRITE_REG) begin
         ref_mem[ptr] = wdata;
      end else if (!mute_on) begin
         last_good = ref_mem[ptr];
      end
      v.expect_rdata = last_good;  // kept across writes and nacks
      vec_table[idx] = v;
   endtask

   task automatic build_table();
      logic [31:0] r;
      logic [7:0]  rp;
      logic [7:0]  rd;
      logic [7:0]  rp2;
      for (int i = 0; i < 256; i++) begin
         ref_mem[i] = 8'(i) ^ 8'hA5;
      end
      last_good = 8'd0;
      r   = $random(seed);
      rp  = r[7:0];
      rd  = r[15:8];
      rp2 = r[23:16];
      if (rp2 == rp) begin
         rp2 = rp + 8'd1;
      end
      set_entry(0, OP_READ_REG, 8'h00, 8'h00, 1'b0);
      set_entry(1, OP_READ_REG, 8'h5A, 8'h00, 1'b0);
      set_entry(2, OP_READ_REG, 8'hFF, 8'h00, 1'b0);
      set_entry(3, OP_READ_REG, 8'h13, 8'h00, 1'b0);
      set_entry(4, OP_WRITE_REG, rp, rd, 1'b0);
      set_entry(5, OP_READ_REG, rp, 8'h00, 1'b0);
      set_entry(6, OP_READ_REG, 8'h40, 8'h00, 1'b1);  // muted target
      set_entry(7, OP_READ_REG, rp2, 8'h00, 1'b0);
   endtask

   task automatic apply_vector(input int idx);
      test_vec_t   v;
      logic [15:0] st;
      int          err_before;
      v          = vec_table[idx];
      err_before = errors;
      mute       = v.mute;
      wb_write(REG_PTR, {8'd0, v.ptr});
      wb_write(REG_WDATA, {8'd0, v.wdata});
      wb_write(REG_CMD, {15'd0, v.op});
      poll_done(st);
      check("busy", 16'd0, {15'd0, st[STAT_BUSY]});
      check("done", 16'd1, {15'd0, st[STAT_DONE]});
      check("nack", {15'd0, v.expect_nack}, {15'd0, st[STAT_NACK]});
      check("rdata", {8'd0, v.expect_rdata}, {8'd0, st[15:8]});
      report_test($sformatf("%0d %s ptr %h", idx, v.op.name(), v.ptr), err_before);
   endtask

   initial begin
      logic [15:0] st;
      int          err_before;
      int          stops_before;
      seed      = 32'h3af95002;
      errors    = 0;
      passes    = 0;
      fails     = 0;
      timed_out = 1'b0;
      wb_req    = '0;
      mute      = 1'b0;
      build_table();

      for (int n = 0; n < 20 && reset !== 1'b1; n++) begin
         @(posedge clk_4x);
      end
      if (reset !== 1'b1) begin
         $display("reset never released");
         timed_out = 1'b1;
      end

      err_before = errors;
      wb_read(REG_STATUS, st);
      check("status", 16'd0, st);
      check("scl_low", 16'd0, {15'd0, scl_low});
      check("sda_low", 16'd0, {15'd0, sda_low});
      report_test("reset", err_before);

      for (int i = 0; i < NUM_VEC; i++) begin
         apply_vector(i);
      end

      // second command lands while the first read is running
      err_before   = errors;
      mute         = 1'b0;
      stops_before = stop_count;
      wb_write(REG_PTR, 16'h0022);
      wb_write(REG_CMD, {15'd0, OP_READ_REG});
      wb_write(REG_CMD, {15'd0, OP_WRITE_REG});
      wb_read(REG_CMD, st);
      check("cmd", {15'd0, OP_READ_REG}, st);
      poll_done(st);
      check("done", 16'd1, {15'd0, st[STAT_DONE]});
      check("nack", 16'd0, {15'd0, st[STAT_NACK]});
      check("rdata", {8'd0, ref_mem[8'h22]}, {8'd0, st[15:8]});
      check("transfers", 16'd1, 16'(stop_count - stops_before));
      report_test("busy drop", err_before);

      $display("tests passed %0d failed %0d", passes, fails);
      if (fails == 0 && errors == 0 && !timed_out) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

//--- tb_i2c_target.sv
module tb_i2c_target #(
   parameter logic [6:0] ADDR = 7'h68
) (
   input  logic clk,
   input  logic scl_low,
   input  logic sda_low,
   input  logic mute,
   output logic sda_line,
   output int   stop_count
);
   timeunit 1ns;
   timeprecision 100ps;

   typedef enum logic [2:0] {T_IDLE, T_ADDR, T_PTR, T_WDATA, T_READ} tgt_phase_e;

   tgt_phase_e phase;
   logic [7:0] mem [256];
   logic [7:0] shift;
   logic [7:0] tx;
   logic [7:0] ptr;
   logic [3:0] cnt;       // 8 marks the ack bit
   logic       drive_low;
   logic       scl_q;
   logic       sda_q;
   logic       skip_fall;  // scl fall that closes a start
   logic       rw;
   logic       scl;
   logic       addr_hit;

   assign scl      = !scl_low;
   assign sda_line = !(sda_low || drive_low);  // pull-up
   assign addr_hit = (shift[7:1] == ADDR) && !mute;

   initial begin
      for (int i = 0; i < 256; i++) begin
         mem[i] = 8'(i) ^ 8'hA5;
      end
      phase      = T_IDLE;
      drive_low  = 1'b0;
      scl_q      = 1'b1;
      sda_q      = 1'b1;
      skip_fall  = 1'b0;
      cnt        = 4'd0;
      ptr        = 8'd0;
      rw         = 1'b0;
      stop_count = 0;
   end

   // lines sampled on clk so the model sees settled levels
   always @(posedge clk) begin
      scl_q <= scl;
      sda_q <= sda_line;
      if (scl && scl_q && sda_q && !sda_line) begin  // start or restart
         phase     <= T_ADDR;
         cnt       <= 4'd0;
         skip_fall <= 1'b1;
         drive_low <= 1'b0;
      end else if (scl && scl_q && !sda_q && sda_line) begin  // stop
         phase      <= T_IDLE;
         drive_low  <= 1'b0;
         stop_count <= stop_count + 1;
      end else if (phase != T_IDLE) begin
         if (scl && !scl_q && cnt < 4'd8) begin
            shift <= {shift[6:0], sda_line};
         end else if (!scl && scl_q) begin
            if (skip_fall) begin
               skip_fall <= 1'b0;
            end else if (cnt < 4'd7) begin
               cnt <= cnt + 4'd1;
               if (phase == T_READ) begin
                  drive_low <= !tx[7];
                  tx        <= tx << 1;
               end
            end else if (cnt == 4'd7) begin
               cnt <= 4'd8;
               case (phase)
                  T_ADDR: begin
                     drive_low <= addr_hit;
                     rw        <= shift[0];
                     if (!addr_hit) begin
                        phase <= T_IDLE;  // stays off the bus when not addressed
                     end
                  end
                  T_PTR: begin
                     ptr       <= shift;
                     drive_low <= 1'b1;
                  end
                  T_WDATA: begin
                     mem[ptr]  <= shift;
                     ptr       <= ptr + 8'd1;
                     drive_low <= 1'b1;
                  end
                  default: drive_low <= 1'b0;  // released for the master nack
               endcase
            end else begin
               cnt       <= 4'd0;
               drive_low <= 1'b0;
               case (phase)
                  T_ADDR: begin
                     if (rw) begin
                        phase     <= T_READ;
                        drive_low <= !mem[ptr][7];
                        tx        <= mem[ptr] << 1;
                     end else begin
                        phase <= T_PTR;
                     end
                  end
                  T_PTR:   phase <= T_WDATA;
                  T_READ:  phase <= T_IDLE;
                  default: ;
               endcase
            end
         end
      end
   end

endmodule

//--- tb_clock_gen.sv
module tb_clock_gen (
   output logic clk_4x,
   output logic reset
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk_4x = 1'b0;
      forever #4 clk_4x = ~clk_4x;  // 8 ns period
   end

   initial begin
      reset = 1'b0;  // active low
      repeat (5) @(posedge clk_4x);
      #1 reset = 1'b1;
   end

endmodule

//--- i2c_read_master.sv
module i2c_read_master #(
   parameter logic [6:0] TARGET_ADDR = 7'h68
) (
   input  logic            clk_4x,
   input  logic            reset,
   input  wb_pkg::wb_req_t wb_req,
   output wb_pkg::wb_rsp_t wb_rsp,
   output logic            scl_low,
   output logic            sda_low,
   input  logic            sda_line
);
   import i2c_pkg::*;

   i2c_cmd_t   cmd;
   logic       launch;
   logic       busy;
   i2c_res_t   res;
   logic       res_valid;
   logic       done;
   logic       nack;
   logic [7:0] rdata;

   i2c_reg_decode i_decode (
      .clk_4x (clk_4x),
      .reset  (reset),
      .wb_req (wb_req),
      .wb_rsp (wb_rsp),
      .cmd    (cmd),
      .launch (launch),
      .busy   (busy),
      .done   (done),
      .nack   (nack),
      .rdata  (rdata)
   );

   i2c_byte_engine #(
      .TARGET_ADDR (TARGET_ADDR)
   ) i_engine (
      .clk_4x    (clk_4x),
      .reset     (reset),
      .cmd       (cmd),
      .launch    (launch),
      .busy      (busy),
      .res       (res),
      .res_valid (res_valid),
      .scl_low   (scl_low),
      .sda_low   (sda_low),
      .sda_line  (sda_line)
   );

   i2c_read_result i_result (
      .clk_4x    (clk_4x),
      .reset     (reset),
      .launch    (launch),
      .res       (res),
      .res_valid (res_valid),
      .done      (done),
      .nack      (nack),
      .rdata     (rdata)
   );

endmodule

//--- i2c_read_result.sv
module i2c_read_result (
   input  logic              clk_4x,
   input  logic              reset,
   input  logic              launch,
   input  i2c_pkg::i2c_res_t res,
   input  logic              res_valid,
   output logic              done,
   output logic              nack,
   output logic [7:0]        rdata
);

   logic take_byte;

   // a nacked transfer never reaches the read byte
   assign take_byte = res_valid && !res.nack;

   always_ff @(posedge clk_4x) begin
      if (!reset) begin
         done  <= 1'b0;
         nack  <= 1'b0;
         rdata <= '0;
      end else begin
         if (launch) begin
            done <= 1'b0;  // new command clears the old outcome
            nack <= 1'b0;
         end else if (res_valid) begin
            done <= 1'b1;
            nack <= res.nack;
         end
         if (take_byte) begin
            rdata <= res.rdata;  // same byte again after a write
         end
      end
   end

   // the engine reports only while idle and decode launches only then,
   // one cycle apart at the earliest
   a_no_overlap: assert property (@(posedge clk_4x) disable iff (!reset)
      !(res_valid && launch))
      else $error("result and launch in the same cycle");

endmodule

//--- i2c_byte_engine.sv
module i2c_byte_engine #(
   parameter logic [6:0] TARGET_ADDR = 7'h68
) (
   input  logic              clk_4x,
   input  logic              reset,
   input  i2c_pkg::i2c_cmd_t cmd,
   input  logic              launch,
   output logic              busy,
   output i2c_pkg::i2c_res_t res,
   output logic              res_valid,
   output logic              scl_low,
   output logic              sda_low,
   input  logic              sda_line
);
   import i2c_pkg::*;

   eng_state_e state;
   logic [1:0] quarter;    // q0..q3 within one bit
   logic [2:0] bit_cnt;    // bit index inside a byte
   i2c_cmd_t   cmd_q;      // command held for the whole transfer
   logic [7:0] tx_shift;   // address, pointer or write byte, msb first
   logic [7:0] rx_byte;
   logic       sda_smp;    // line level seen at the start of q3
   logic       nack_flag;
   logic       bit_end;
   logic       data_bit;
   logic       ack_slot;
   logic       last_bit;

   assign busy     = (state != ST_IDLE);
   assign bit_end  = busy && (quarter == 2'd3);
   assign last_bit = (bit_cnt == 3'd7);
   assign data_bit = state inside {ST_ADDR_W, ST_PTR, ST_WDATA, ST_ADDR_R, ST_READ};
   assign ack_slot = state inside {ST_ACK_A, ST_ACK_P, ST_ACK_D, ST_ACK_R};

   assign res = '{nack: nack_flag, rdata: rx_byte};

   always_ff @(posedge clk_4x) begin
      if (!reset) begin
         state     <= ST_IDLE;
         quarter   <= '0;
         bit_cnt   <= '0;
         nack_flag <= 1'b0;
         res_valid <= 1'b0;
         rx_byte   <= '0;  // holds the last good read byte across writes
      end else begin
         res_valid <= 1'b0;
         if (state == ST_IDLE) begin
            quarter <= '0;
            bit_cnt <= '0;
            if (launch) begin
               state     <= ST_START;
               nack_flag <= 1'b0;
            end
         end else begin
            quarter <= quarter + 2'd1;
            if (bit_end) begin
               bit_cnt <= data_bit ? bit_cnt + 3'd1 : 3'd0;  // wraps after bit 7
               if (ack_slot && sda_smp) begin
                  nack_flag <= 1'b1;
               end
               if (state == ST_READ) begin
                  rx_byte <= {rx_byte[6:0], sda_smp};
               end
               case (state)
                  ST_START:   state <= ST_ADDR_W;
                  ST_ADDR_W:  if (last_bit) state <= ST_ACK_A;
                  ST_ACK_A:   state <= sda_smp ? ST_STOP : ST_PTR;
                  ST_PTR:     if (last_bit) state <= ST_ACK_P;
                  ST_ACK_P: begin
                     if (sda_smp) begin
                        state <= ST_STOP;
                     end else if (cmd_q.op == OP_WRITE_REG) begin
                        state <= ST_WDATA;
                     end else begin
                        state <= ST_RESTART;
                     end
                  end
                  ST_WDATA:   if (last_bit) state <= ST_ACK_D;
                  ST_ACK_D:   state <= ST_STOP;  // nack here is only flagged
                  ST_RESTART: state <= ST_ADDR_R;
                  ST_ADDR_R:  if (last_bit) state <= ST_ACK_R;
                  ST_ACK_R:   state <= sda_smp ? ST_STOP : ST_READ;
                  ST_READ:    if (last_bit) state <= ST_MNACK;
                  ST_MNACK:   state <= ST_STOP;
                  ST_STOP: begin
                     state     <= ST_IDLE;
                     res_valid <= 1'b1;
                  end
                  default:    state <= ST_IDLE;
               endcase
            end
         end
      end
   end

   // datapath, reloaded at the end of the bit before each byte
   always_ff @(posedge clk_4x) begin
      if (state == ST_IDLE && launch) begin
         cmd_q <= cmd;
      end
      if (bit_end) begin
         case (state)
            ST_START:   tx_shift <= {TARGET_ADDR, 1'b0};
            ST_ACK_A:   tx_shift <= cmd_q.reg_ptr;
            ST_ACK_P:   tx_shift <= cmd_q.wdata;  // unused on a read
            ST_RESTART: tx_shift <= {TARGET_ADDR, 1'b1};
            default:    tx_shift <= {tx_shift[6:0], 1'b0};
         endcase
      end
      if (quarter == 2'd2) begin
         sda_smp <= sda_line;  // scl has been high for one quarter
      end
   end

   // line controls, 1 pulls the line low
   always_comb begin
      scl_low = 1'b0;
      sda_low = 1'b0;
      case (state)
         ST_START: begin
            scl_low = (quarter == 2'd3);
            sda_low = (quarter != 2'd0);  // falls with scl high
         end
         ST_RESTART: begin
            scl_low = (quarter == 2'd0) || (quarter == 2'd3);
            sda_low = quarter[1];
         end
         ST_STOP: begin
            scl_low = !quarter[1];
            sda_low = (quarter != 2'd3);  // released with scl high
         end
         ST_ADDR_W, ST_PTR, ST_WDATA, ST_ADDR_R: begin
            scl_low = !quarter[1];
            sda_low = !tx_shift[7];
         end
         ST_ACK_A, ST_ACK_P, ST_ACK_D, ST_ACK_R, ST_READ, ST_MNACK: begin
            scl_low = !quarter[1];  // sda left to the target or high
         end
         default: ;
      endcase
   end

   // decode only launches while the engine is idle
   a_launch_idle: assert property (@(posedge clk_4x) disable iff (!reset)
      launch |-> !busy)
      else $error("launch while engine busy");

   // sda may move under a high scl only for start, restart and stop
   a_sda_stable: assert property (@(posedge clk_4x) disable iff (!reset)
      (sda_low != $past(sda_low)) && !scl_low && !$past(scl_low)
      |-> state inside {ST_START, ST_RESTART, ST_STOP})
      else $error("sda moved while scl high in state %s", state.name());

endmodule

//--- i2c_reg_decode.sv
module i2c_reg_decode (
   input  logic              clk_4x,
   input  logic              reset,
   input  wb_pkg::wb_req_t   wb_req,
   output wb_pkg::wb_rsp_t   wb_rsp,
   output i2c_pkg::i2c_cmd_t cmd,
   output logic              launch,
   input  logic              busy,
   input  logic              done,
   input  logic              nack,
   input  logic [7:0]        rdata
);
   import wb_pkg::*;
   import i2c_pkg::*;

   logic        ack;
   logic        xfer;
   reg_sel_e    sel;
   logic [15:0] status;
   logic [15:0] rd_dat;
   logic [7:0]  ptr_q;
   logic [7:0]  wdata_q;
   cmd_op_e     op_q;

   assign xfer = wb_req.cyc && wb_req.stb && !ack;  // no new transfer in the ack cycle
   assign sel  = reg_sel_e'(wb_req.adr);

   always_comb begin
      status = '0;
      status[STAT_BUSY] = busy;
      status[STAT_DONE] = done;
      status[STAT_NACK] = nack;
      status[STAT_RD_LO +: 8] = rdata;
   end

   assign cmd    = '{op: op_q, reg_ptr: ptr_q, wdata: wdata_q};
   assign wb_rsp = '{ack: ack, dat: rd_dat};

   always_ff @(posedge clk_4x) begin
      if (!reset) begin
         ack    <= 1'b0;
         launch <= 1'b0;
      end else begin
         ack    <= xfer;
         // a command while the engine runs is acked and dropped
         launch <= xfer && wb_req.we && (sel == REG_CMD) && !busy;
      end
   end

   // host-visible register contents
   always_ff @(posedge clk_4x) begin
      if (xfer && wb_req.we) begin
         case (sel)
            REG_PTR:   ptr_q   <= wb_req.dat[7:0];
            REG_WDATA: wdata_q <= wb_req.dat[7:0];
            REG_CMD: begin
               if (!busy) begin
                  op_q <= cmd_op_e'(wb_req.dat[0]);  // only an accepted opcode sticks
               end
            end
            default: ;
         endcase
      end
   end

   // read data registered with ack
   always_ff @(posedge clk_4x) begin
      if (xfer) begin
         case (sel)
            REG_PTR:    rd_dat <= {8'd0, ptr_q};
            REG_WDATA:  rd_dat <= {8'd0, wdata_q};
            REG_CMD:    rd_dat <= {15'd0, op_q};
            REG_STATUS: rd_dat <= status;
            default:    rd_dat <= '0;
         endcase
      end
   end

   // each transfer gets a single-cycle ack
   a_ack_single: assert property (@(posedge clk_4x) disable iff (!reset)
      ack |=> !ack)
      else $error("ack held for two cycles");

endmodule

//--- i2c_pkg.sv
package i2c_pkg;

   typedef enum logic {
      OP_READ_REG  = 1'b0,  // ptr write, restart, one byte read
      OP_WRITE_REG = 1'b1   // ptr write then data byte
   } cmd_op_e;

   // one state per bit group on the wire
   typedef enum logic [3:0] {
      ST_IDLE    = 4'd0,
      ST_START   = 4'd1,
      ST_ADDR_W  = 4'd2,   // address plus write bit
      ST_ACK_A   = 4'd3,
      ST_PTR     = 4'd4,
      ST_ACK_P   = 4'd5,
      ST_WDATA   = 4'd6,
      ST_ACK_D   = 4'd7,
      ST_RESTART = 4'd8,
      ST_ADDR_R  = 4'd9,   // address plus read bit
      ST_ACK_R   = 4'd10,
      ST_READ    = 4'd11,
      ST_MNACK   = 4'd12,  // master nack after the read byte
      ST_STOP    = 4'd13
   } eng_state_e;

   // command handed from the register block to the engine
   typedef struct packed {
      cmd_op_e    op;
      logic [7:0] reg_ptr;
      logic [7:0] wdata;
   } i2c_cmd_t;

   // outcome of one transfer
   typedef struct packed {
      logic       nack;   // some ack slot sampled high
      logic [7:0] rdata;  // last byte shifted in
   } i2c_res_t;

endpackage

//--- wb_pkg.sv
package wb_pkg;

   // host register map, word addressed
   typedef enum logic [1:0] {
      REG_PTR    = 2'd0,  // target register pointer
      REG_WDATA  = 2'd1,  // byte for a register write
      REG_CMD    = 2'd2,  // bit 0 opcode, a write launches
      REG_STATUS = 2'd3   // read only
   } reg_sel_e;

   // bit positions inside the status word
   localparam int STAT_BUSY  = 0;
   localparam int STAT_DONE  = 1;
   localparam int STAT_NACK  = 2;
   localparam int STAT_RD_LO = 8;  // received byte sits in 15:8

   // classic cycle, transfer when cyc and stb are both high
   typedef struct packed {
      logic        cyc;
      logic        stb;
      logic        we;
      logic [1:0]  adr;
      logic [15:0] dat;
   } wb_req_t;

   typedef struct packed {
      logic        ack;  // one cycle per transfer
      logic [15:0] dat;  // valid while ack is high
   } wb_rsp_t;

endpackage
